/* compile.f */
+incdir+hw
hw/muldiv_pkg.sv
hw/arith_if.sv
hw/seq_divider.sv
hw/seq_multiplier.sv
hw/muldiv_ctrl.sv
hw/muldiv_top.sv
sim/muldiv_tb.sv

/* hw/arith_if.sv */
`timescale 1ns/1ns

`include "muldiv_cfg.svh"

// link between the controller and one iterative block
interface arith_if
	import muldiv_pkg::*;
();

	// one-cycle load strobe from the controller
	logic start;
	// unsigned magnitudes
	word_t opa;
	word_t opb;
	// results, valid while done is high
	word_t res_hi;
	word_t res_lo;
	// level, cleared by start
	logic done;

	// controller side
	modport master
	(
		output start, opa, opb,
		input  res_hi, res_lo, done
	);

	// arithmetic block side
	modport unit
	(
		input  start, opa, opb,
		output res_hi, res_lo, done
	);

endinterface

/* hw/muldiv_cfg.svh */
`ifndef MULDIV_CFG_SVH
`define MULDIV_CFG_SVH

// cpu word width
// operands, hi and lo all use it
`define MD_WIDTH 32

// iteration counter width
// one iteration per operand bit, so 2**MD_CNT_W must equal MD_WIDTH
`define MD_CNT_W 5

// both arithmetic blocks and the controller
// count 0 .. 2**MD_CNT_W-1

`endif

/* hw/muldiv_ctrl.sv */
`timescale 1ns/1ns

`include "muldiv_cfg.svh"

// sequencing, sign handling and the hi/lo registers
module muldiv_ctrl
	import muldiv_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input md_op_e op,
	input word_t a,
	input word_t b,
	output logic busy,
	output word_t hi,
	output word_t lo,
	arith_if.master div_bus,
	arith_if.master mul_bus
);

	ctrl_state_e state;
	md_op_e op_q;
	// magnitudes handed to the blocks
	word_t mag_a;
	word_t mag_b;
	// sign of product or quotient
	logic neg_lo;
	// sign of remainder, divide only
	logic neg_hi;
	// tracks the block iterations
	logic [`MD_CNT_W-1:0] cnt;

	logic is_div;
	logic is_signed;

	// corrected results
	dword_t prod;
	dword_t prod_fix;
	word_t quo_fix;
	word_t rem_fix;

	assign is_div = (op_q == OP_DIV) || (op_q == OP_DIVU);
	assign is_signed = (op == OP_MULT) || (op == OP_DIV);

	always_comb
	begin
		prod = {mul_bus.res_hi, mul_bus.res_lo};
		prod_fix = neg_lo ? -prod : prod;
		// quotient and remainder negate on their own
		quo_fix = neg_lo ? -div_bus.res_lo : div_bus.res_lo;
		rem_fix = neg_hi ? -div_bus.res_hi : div_bus.res_hi;
	end

	// only the selected block sees a start
	assign div_bus.start = (state == ST_LAUNCH) && is_div;
	assign mul_bus.start = (state == ST_LAUNCH) && !is_div;
	assign div_bus.opa = mag_a;
	assign div_bus.opb = mag_b;
	assign mul_bus.opa = mag_a;
	assign mul_bus.opb = mag_b;

	// operand latch, payload only
	always_ff @(posedge clk)
	begin
		if (state == ST_IDLE && start)
		begin
			op_q <= op;
			// |min| is the same bit pattern, fine as unsigned
			mag_a <= (is_signed && a[`MD_WIDTH-1]) ? -a : a;
			mag_b <= (is_signed && b[`MD_WIDTH-1]) ? -b : b;
			// xor of signs for product and quotient
			neg_lo <= is_signed && (a[`MD_WIDTH-1] ^ b[`MD_WIDTH-1]);
			// remainder follows the dividend
			neg_hi <= is_signed && a[`MD_WIDTH-1];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			busy <= 1'b0;
			cnt <= '0;
			hi <= '0;
			lo <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					// edge 0
					if (start)
					begin
						busy <= 1'b1;
						state <= ST_LAUNCH;
					end
				end
				ST_LAUNCH:
				begin
					// edge 1, block loads here
					cnt <= '0;
					state <= ST_RUN;
				end
				ST_RUN:
				begin
					// edges 2 to 33
					cnt <= cnt + 1'b1;
					if (cnt == '1)
						state <= ST_FINISH;
				end
				ST_FINISH:
				begin
					// edge 34, done is high by now
					if (is_div)
					begin
						hi <= rem_fix;
						lo <= quo_fix;
					end
					else
					begin
						hi <= prod_fix[2*`MD_WIDTH-1:`MD_WIDTH];
						lo <= prod_fix[`MD_WIDTH-1:0];
					end
					busy <= 1'b0;
					state <= ST_IDLE;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// busy drops out of FINISH after exactly 34 cycles high
	a_busy_fall: assert property (@(posedge clk) disable iff (rst)
		$fell(busy) |-> ($past(state) == ST_FINISH)
			&& $past(busy, 34) && !$past(busy, 35));

	// controller count must line up with the block count
	a_done_in_finish: assert property (@(posedge clk) disable iff (rst)
		(state == ST_FINISH) |-> (is_div ? div_bus.done : mul_bus.done));

endmodule

/* hw/muldiv_pkg.sv */
`include "muldiv_cfg.svh"

package muldiv_pkg;

	// one operand or result word
	typedef logic [`MD_WIDTH-1:0] word_t;

	// work register of the iterative blocks, also the full product
	typedef logic [2*`MD_WIDTH-1:0] dword_t;

	// operation codes seen on the op input
	typedef enum logic [1:0]
	{
		OP_MULT  = 2'd0,
		OP_MULTU = 2'd1,
		OP_DIV   = 2'd2,
		OP_DIVU  = 2'd3
	} md_op_e;

	// controller sequence
	typedef enum logic [1:0]
	{
		ST_IDLE   = 2'd0,
		ST_LAUNCH = 2'd1,
		ST_RUN    = 2'd2,
		ST_FINISH = 2'd3
	} ctrl_state_e;

endpackage

/* hw/muldiv_top.sv */
`timescale 1ns/1ns

// multiply/divide unit for the cpu core
module muldiv_top
	import muldiv_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic [1:0] op,
	input word_t a,
	input word_t b,
	output logic busy,
	output word_t hi,
	output word_t lo
);

	// one bus per arithmetic block
	arith_if div_bus ();
	arith_if mul_bus ();

	muldiv_ctrl i_muldiv_ctrl
	(
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.op      (md_op_e'(op)),
		.a       (a),
		.b       (b),
		.busy    (busy),
		.hi      (hi),
		.lo      (lo),
		.div_bus (div_bus.master),
		.mul_bus (mul_bus.master)
	);

	seq_divider i_seq_divider
	(
		.clk (clk),
		.rst (rst),
		.bus (div_bus.unit)
	);

	seq_multiplier i_seq_multiplier
	(
		.clk (clk),
		.rst (rst),
		.bus (mul_bus.unit)
	);

endmodule

/* hw/seq_divider.sv */
`timescale 1ns/1ns

`include "muldiv_cfg.svh"

// restoring divider, one quotient bit per cycle
// opa is the dividend, opb the divisor, both unsigned
module seq_divider
	import muldiv_pkg::*;
(
	input logic clk,
	input logic rst,
	arith_if.unit bus
);

	// upper half partial remainder, lower half dividend then quotient
	dword_t work;
	word_t divisor;
	logic running;
	logic done;
	logic [`MD_CNT_W-1:0] cnt;

	// trial subtraction on the shifted upper slice
	// 33 bit slice, one more bit for the sign
	logic [`MD_WIDTH+1:0] trial;

	assign trial = {1'b0, work[2*`MD_WIDTH-1:`MD_WIDTH-1]} - {2'b00, divisor};

	// payload, no reset
	always_ff @(posedge clk)
	begin
		if (bus.start)
		begin
			divisor <= bus.opb;
			work <= {{`MD_WIDTH{1'b0}}, bus.opa};
		end
		else if (running)
		begin
			// non-negative: keep difference and shift in a 1
			if (!trial[`MD_WIDTH+1])
				work <= {trial[`MD_WIDTH-1:0], work[`MD_WIDTH-2:0], 1'b1};
			else
				work <= {work[2*`MD_WIDTH-2:0], 1'b0};
		end
	end

	// control, fixed 32 iterations even for a zero divisor
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			running <= 1'b0;
			done <= 1'b0;
			cnt <= '0;
		end
		else if (bus.start)
		begin
			running <= 1'b1;
			done <= 1'b0;
			cnt <= '0;
		end
		else if (running)
		begin
			cnt <= cnt + 1'b1;
			// last iteration
			if (cnt == '1)
			begin
				running <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	assign bus.done = done;
	// remainder on hi, quotient on lo
	assign bus.res_hi = work[2*`MD_WIDTH-1:`MD_WIDTH];
	assign bus.res_lo = work[`MD_WIDTH-1:0];

	// controller must wait for done
	a_no_start_in_run: assert property (@(posedge clk) disable iff (rst)
		bus.start |-> !running);

	// done rises exactly one count after the last iteration
	a_done_latency: assert property (@(posedge clk) disable iff (rst)
		bus.start |-> ##33 $rose(bus.done));

endmodule

/* hw/seq_multiplier.sv */
`timescale 1ns/1ns

`include "muldiv_cfg.svh"

// shift-add multiplier, one multiplier bit per cycle
// opa is the multiplicand, opb the multiplier, both unsigned
module seq_multiplier
	import muldiv_pkg::*;
(
	input logic clk,
	input logic rst,
	arith_if.unit bus
);

	// upper half accumulator, lower half multiplier shifting out
	dword_t work;
	word_t mcand;
	logic running;
	logic done;
	logic [`MD_CNT_W-1:0] cnt;

	// conditional add, carry kept in the top bit
	logic [`MD_WIDTH:0] sum;

	assign sum = {1'b0, work[2*`MD_WIDTH-1:`MD_WIDTH]}
		+ {1'b0, work[0] ? mcand : {`MD_WIDTH{1'b0}}};

	always_ff @(posedge clk)
	begin
		if (bus.start)
		begin
			mcand <= bus.opa;
			work <= {{`MD_WIDTH{1'b0}}, bus.opb};
		end
		else if (running)
			// shift right, carry drops into the msb
			work <= {sum, work[`MD_WIDTH-1:1]};
	end

	// same counter and done behaviour as the divider
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			running <= 1'b0;
			done <= 1'b0;
			cnt <= '0;
		end
		else if (bus.start)
		begin
			running <= 1'b1;
			done <= 1'b0;
			cnt <= '0;
		end
		else if (running)
		begin
			cnt <= cnt + 1'b1;
			if (cnt == '1)
			begin
				running <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	assign bus.done = done;
	assign bus.res_hi = work[2*`MD_WIDTH-1:`MD_WIDTH];
	assign bus.res_lo = work[`MD_WIDTH-1:0];

	// every done comes from a start 33 edges back
	a_done_after_start: assert property (@(posedge clk) disable iff (rst)
		$rose(bus.done) |-> $past(bus.start, 33));

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the muldiv testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f compile.f --top-module muldiv_tb -o muldiv_sim \
	|| { echo "build failed"; exit 1; }

./obj_dir/muldiv_sim > sim.log 2>&1 || true
cat sim.log

grep -q "TEST FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "simulation ended without passing"; exit 1; }
echo "simulation ok"

/* sim/muldiv_tb.sv */
`timescale 1ns/1ns

// testbench for the multiply/divide unit
module muldiv_tb
	import muldiv_pkg::*;
();

	logic clk = 1'b0;
	logic rst;
	logic start;
	logic [1:0] op;
	word_t a;
	word_t b;
	logic busy;
	word_t hi;
	word_t lo;

	// stimulus generator state
	logic [31:0] lfsr;

	muldiv_top i_muldiv_top
	(
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.op    (op),
		.a     (a),
		.b     (b),
		.busy  (busy),
		.hi    (hi),
		.lo    (lo)
	);

	// 100 ns period
	always #50 clk = ~clk;

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit taken
	task automatic draw_bits(input int n, output word_t val);
		int k;
		val = '0;
		for (k = 0; k < n; k++)
		begin
			lfsr = lfsr_next(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t expv, input word_t actv);
		assert (actv === expv)
		else
			fail_now($sformatf("[ERROR] time %0t: %s expected %h, got %h",
				$time, name, expv, actv));
	endtask

	task automatic check_count(input string name, input int expv, input int actv);
		assert (actv == expv)
		else
			fail_now($sformatf("[ERROR] time %0t: %s expected %0d, got %0d",
				$time, name, expv, actv));
	endtask

	// expected {hi, lo}
	function automatic dword_t model_result(input md_op_e code, input word_t x, input word_t y);
		dword_t ex;
		dword_t ey;
		int sx;
		int sy;
		word_t q;
		word_t r;
		ex = {32'd0, x};
		ey = {32'd0, y};
		sx = x;
		sy = y;
		// divide by zero defaults
		q = '1;
		r = x;
		case (code)
			OP_MULTU:
				return ex * ey;
			OP_MULT:
			begin
				// sign extended, low 64 bits are the signed product
				ex = {{32{x[31]}}, x};
				ey = {{32{y[31]}}, y};
				return ex * ey;
			end
			OP_DIVU:
			begin
				if (y != 32'd0)
				begin
					q = x / y;
					r = x % y;
				end
			end
			default:
			begin
				// negative dividend over zero gives minus all-ones
				if (y == 32'd0)
				begin
					if (x[31])
						q = 32'd1;
				end
				else if (x == 32'h8000_0000 && y == 32'hffff_ffff)
				begin
					q = x;
					r = '0;
				end
				else
				begin
					// truncating division, remainder follows dividend
					q = sx / sy;
					r = sx % sy;
				end
			end
		endcase
		return {r, q};
	endfunction

	task automatic wait_idle();
		int guard;
		guard = 0;
		while (busy !== 1'b0)
		begin
			@(negedge clk);
			guard++;
			if (guard > 100)
				fail_now("timeout: busy never returned low");
		end
	endtask

	// one operation, poke adds a start with other operands while busy
	task automatic run_op(input md_op_e code, input word_t opa, input word_t opb, input bit poke);
		dword_t expv;
		word_t hi_before;
		word_t lo_before;
		int cycles;
		expv = model_result(code, opa, opb);
		wait_idle();
		@(posedge clk);
		start <= 1'b1;
		op <= code;
		a <= opa;
		b <= opb;
		// edge 0 samples the start
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		assert (busy === 1'b1)
		else
			fail_now("busy did not rise after an accepted start");
		hi_before = hi;
		lo_before = lo;
		cycles = 1;
		while (busy === 1'b1)
		begin
			@(posedge clk);
			if (poke && cycles == 10)
			begin
				start <= 1'b1;
				op <= code ^ 2'b01;
				a <= ~opa;
				b <= ~opb;
			end
			else if (poke && cycles == 11)
				start <= 1'b0;
			@(negedge clk);
			if (busy === 1'b1)
			begin
				check_word("hi", hi_before, hi);
				check_word("lo", lo_before, lo);
				cycles++;
			end
			if (cycles > 100)
				fail_now("timeout: busy stayed high");
		end
		check_count("busy cycles", 34, cycles);
		check_word("hi", expv[63:32], hi);
		check_word("lo", expv[31:0], lo);
	endtask

	initial
	begin
		int i;
		word_t r_op;
		word_t r_a;
		word_t r_b;
		word_t r_sel;
		word_t r_small;
		md_op_e code;
		rst = 1'b1;
		start = 1'b0;
		op = 2'd0;
		a = '0;
		b = '0;
		lfsr = 32'ha42;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_word("busy", 32'd0, {31'd0, busy});
		check_word("hi", 32'd0, hi);
		check_word("lo", 32'd0, lo);

		// multiply corners
		run_op(OP_MULT, -32'sd7, -32'sd9, 1'b0);
		run_op(OP_MULT, 32'h8000_0000, 32'h8000_0000, 1'b0);
		run_op(OP_MULT, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
		run_op(OP_MULTU, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
		run_op(OP_MULTU, 32'd0, 32'h1234_5678, 1'b1);
		// every sign combination
		run_op(OP_DIV, 32'd100, 32'd7, 1'b0);
		run_op(OP_DIV, -32'sd100, 32'd7, 1'b0);
		run_op(OP_DIV, 32'd100, -32'sd7, 1'b0);
		run_op(OP_DIV, -32'sd100, -32'sd7, 1'b1);
		// zero divisor and overflow case
		run_op(OP_DIVU, 32'd12345, 32'd0, 1'b0);
		run_op(OP_DIV, 32'd12345, 32'd0, 1'b0);
		run_op(OP_DIV, -32'sd12345, 32'd0, 1'b0);
		run_op(OP_DIV, 32'h8000_0000, 32'hffff_ffff, 1'b0);
		run_op(OP_DIVU, 32'h8000_0000, 32'hffff_ffff, 1'b0);

		for (i = 0; i < 200; i++)
		begin
			draw_bits(2, r_op);
			draw_bits(32, r_a);
			draw_bits(32, r_b);
			draw_bits(3, r_sel);
			code = md_op_e'(r_op[1:0]);
			case (r_sel[2:0])
				3'd0: r_a = '0;
				3'd1: r_b = '1;
				3'd2, 3'd3, 3'd4:
				begin
					// small divisor for a large quotient
					if (code == OP_DIV || code == OP_DIVU)
					begin
						draw_bits(4, r_small);
						r_b = r_b[31] ? -r_small : r_small;
					end
				end
				default: ;
			endcase
			run_op(code, r_a, r_b, (i % 16) == 5);
		end

		$display("TEST PASSED");
		$finish;
	end

endmodule
